// File: Makefile
SRCS := $(shell cat list.f)

all: run

obj_dir/Vtb_link_test: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_link_test -f list.f -o Vtb_link_test

run: obj_dir/Vtb_link_test testbench/link_trace.txt
	./obj_dir/Vtb_link_test +verilator+error+limit+1000 | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: common/link_pkg.sv
package link_pkg;

  localparam int DATA_W = 64;
  localparam int CNT_W  = 10;

  typedef enum logic [1:0] {
    INIT          = 2'd0,
    DELAY_ADJUST  = 2'd1,
    WORD_ALIGN    = 2'd2,
    DATA_TRANSFER = 2'd3
  } link_state_t;

  // Number of pulled words spent in each phase.
  localparam int INIT_LEN   = 64;
  localparam int ADJUST_LEN = 256;
  localparam int ALIGN_LEN  = 1;
  localparam int DATA_LEN   = 1024;

  // Both windows are open at each end, on the down-counter value.
  localparam logic [CNT_W-1:0] PHY_INIT_LO = 64;
  localparam logic [CNT_W-1:0] PHY_INIT_HI = 196;
  localparam logic [CNT_W-1:0] TOGGLE_LO   = 32;
  localparam logic [CNT_W-1:0] TOGGLE_HI   = 224;

  localparam logic [DATA_W-1:0] TOGGLE_WORD = {16{4'hA}};
  localparam logic [DATA_W-1:0] ALIGN_WORD  = 64'hF731_8CEF_137F_FEC8;

  // Counter load value on entry to a phase, i.e. its length minus one.
  function automatic logic [CNT_W-1:0] phase_last(link_state_t s);
    int len;
    case (s)
      INIT:         len = INIT_LEN;
      DELAY_ADJUST: len = ADJUST_LEN;
      WORD_ALIGN:   len = ALIGN_LEN;
      default:      len = DATA_LEN;
    endcase
    len = len - 1;
    return len[CNT_W-1:0];
  endfunction

endpackage

// File: common/link_tx_if.sv
`timescale 1ns/1ps

// Next-cycle view of the training sequencer, consumed by the transmit datapath.
interface link_tx_if;

  link_pkg::link_state_t        next_state;
  logic [link_pkg::CNT_W-1:0]   next_cnt;
  logic                         pull;  // Sink request as seen by the sequencer.
  logic                         clr;

  modport ctrl (
    output next_state,
    output next_cnt,
    output pull,
    output clr
  );

  modport dp (
    input next_state,
    input next_cnt,
    input pull,
    input clr
  );

endinterface

// File: link_tx/link_train_ctrl.sv
`timescale 1ns/1ps

module link_train_ctrl (
  input  logic    CLK,
  input  logic    RSTX,
  input  logic    CLR,
  input  logic    DOPULL,
  output logic    PHY_INIT,
  link_tx_if.ctrl tx
);

  link_pkg::link_state_t        state;
  link_pkg::link_state_t        state_nxt;
  logic [link_pkg::CNT_W-1:0]   cnt;
  logic [link_pkg::CNT_W-1:0]   cnt_nxt;
  logic                         phase_end;
  logic                         phy_init_nxt;

  // The last word of a phase is being pulled.
  assign phase_end = DOPULL && (cnt == '0);

  always_comb begin
    state_nxt = state;
    if (phase_end) begin
      case (state)
        link_pkg::INIT:         state_nxt = link_pkg::DELAY_ADJUST;
        link_pkg::DELAY_ADJUST: state_nxt = link_pkg::WORD_ALIGN;
        link_pkg::WORD_ALIGN:   state_nxt = link_pkg::DATA_TRANSFER;
        default:                state_nxt = link_pkg::DELAY_ADJUST;  // Next frame.
      endcase
    end
  end

  always_comb begin
    if (!DOPULL) begin
      cnt_nxt = cnt;
    end else if (phase_end) begin
      cnt_nxt = link_pkg::phase_last(state_nxt);
    end else begin
      cnt_nxt = cnt - 1'b1;
    end
  end

  assign phy_init_nxt = (state_nxt == link_pkg::DELAY_ADJUST) &&
                        (cnt_nxt > link_pkg::PHY_INIT_LO) &&
                        (cnt_nxt < link_pkg::PHY_INIT_HI);

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      state    <= link_pkg::INIT;
      cnt      <= link_pkg::phase_last(link_pkg::INIT);
      PHY_INIT <= 1'b0;
    end else if (CLR) begin
      state    <= link_pkg::INIT;
      cnt      <= link_pkg::phase_last(link_pkg::INIT);
      PHY_INIT <= 1'b0;
    end else begin
      state    <= state_nxt;
      cnt      <= cnt_nxt;
      PHY_INIT <= phy_init_nxt;  // Lines up with DOUT from the datapath.
    end
  end

  // The datapath registers its outputs from the same next-cycle values.
  assign tx.next_state = state_nxt;
  assign tx.next_cnt   = cnt_nxt;
  assign tx.pull       = DOPULL;
  assign tx.clr        = CLR;

endmodule

// File: link_tx/link_tx_datapath.sv
`timescale 1ns/1ps

module link_tx_datapath (
  input  logic                        CLK,
  input  logic                        RSTX,
  link_tx_if.dp                       tx,
  output logic                        DOPUSH,
  output logic [link_pkg::DATA_W-1:0] DOUT
);

  logic [link_pkg::DATA_W-1:0] test_cnt;
  logic [link_pkg::DATA_W-1:0] test_cnt_nxt;
  logic [link_pkg::DATA_W-1:0] dout_nxt;
  logic                        in_toggle;
  logic                        push_nxt;

  // The test counter runs on across frames, so the second frame starts past the first.
  assign test_cnt_nxt = (tx.pull && tx.next_state == link_pkg::DATA_TRANSFER) ?
                        test_cnt + 1'b1 : test_cnt;

  assign in_toggle = (tx.next_cnt > link_pkg::TOGGLE_LO) &&
                     (tx.next_cnt < link_pkg::TOGGLE_HI);

  always_comb begin
    case (tx.next_state)
      link_pkg::DELAY_ADJUST:  dout_nxt = in_toggle ? link_pkg::TOGGLE_WORD : '0;
      link_pkg::WORD_ALIGN:    dout_nxt = link_pkg::ALIGN_WORD;
      link_pkg::DATA_TRANSFER: dout_nxt = test_cnt_nxt;
      default:                 dout_nxt = '0;
    endcase
  end

  // Pulls during INIT are absorbed without a word.
  assign push_nxt = tx.pull && (tx.next_state != link_pkg::INIT);

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      test_cnt <= '0;
    end else if (tx.clr) begin
      test_cnt <= '0;
    end else begin
      test_cnt <= test_cnt_nxt;
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      DOPUSH <= 1'b0;
      DOUT   <= '0;
    end else if (tx.clr) begin
      DOPUSH <= 1'b0;
      DOUT   <= '0;
    end else begin
      DOPUSH <= push_nxt;
      DOUT   <= dout_nxt;  // Holds its pattern while the sink stalls.
    end
  end

endmodule

// File: list.f
common/link_pkg.sv
common/link_tx_if.sv
link_tx/link_train_ctrl.sv
link_tx/link_tx_datapath.sv
verilog/link_rx_checker.sv
verilog/link_test_top.sv
testbench/tb_clock.sv
testbench/link_test_assertions.sv
testbench/tb_link_test.sv

// File: testbench/link_test_assertions.sv
`timescale 1ns/1ps

module link_test_assertions (
  input logic                       CLK,
  input logic                       RSTX,
  input logic                       CLR,
  input logic                       DOPULL,
  input logic                       PHY_INIT,
  input logic [1:0]                 state,
  input logic [link_pkg::CNT_W-1:0] cnt
);

  int fail_count = 0;  // Read by the testbench at the end of the run.

  function automatic logic [1:0] phase_after(input logic [1:0] s);
    logic [1:0] n;
    case (s)
      link_pkg::INIT:         n = link_pkg::DELAY_ADJUST;
      link_pkg::DELAY_ADJUST: n = link_pkg::WORD_ALIGN;
      link_pkg::WORD_ALIGN:   n = link_pkg::DATA_TRANSFER;
      default:                n = link_pkg::DELAY_ADJUST;
    endcase
    return n;
  endfunction

  // A phase either holds or hands over to the one that follows it.
  no_skip: assert property (@(posedge CLK) disable iff (!RSTX)
    !CLR |=> (state == $past(state)) || (state == phase_after($past(state))))
    else begin
      fail_count++;
      $error("training state skipped a phase");
    end

  hold_on_stall: assert property (@(posedge CLK) disable iff (!RSTX)
    (!DOPULL && !CLR) |=> ($stable(state) && $stable(cnt)))
    else begin
      fail_count++;
      $error("sequencer moved while DOPULL was low");
    end

  phy_init_phase: assert property (@(posedge CLK) disable iff (!RSTX)
    PHY_INIT |-> (state == link_pkg::DELAY_ADJUST))
    else begin
      fail_count++;
      $error("PHY_INIT high outside DELAY_ADJUST");
    end

endmodule

// File: testbench/link_trace.txt
# Columns: command a b. R runs a cycles, pulling always if b is 0 and at random if b is 1.
# C clears, X corrupts the a-th upcoming data word, K expects RX_WORDS a and RX_ERRORS b.
R 1344 0
K 1024 0
X 5 0
R 1281 0
K 2048 1
R 3000 1
C 0 0
K 0 0
X 1024 0
R 1344 0
K 1024 1
R 700 0
C 0 0
R 400 0
K 80 0

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic RSTX
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns period.
  end

  // Reset is held for five rising edges and released on a falling edge.
  initial begin
    RSTX = 1'b0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RSTX = 1'b1;
  end

endmodule

// File: testbench/tb_link_test.sv
`timescale 1ns/1ps

module tb_link_test;

  typedef logic [link_pkg::CNT_W-1:0] cnt_t;

  localparam int MARGIN = 100;

  logic                        CLK;
  logic                        RSTX;
  logic                        CLR;
  logic                        DOPULL;
  logic                        DOPUSH;
  logic                        PHY_INIT;
  logic [link_pkg::DATA_W-1:0] DOUT;
  logic                        RX_VALID;
  logic [link_pkg::DATA_W-1:0] RX_DATA;
  logic                        RX_ALIGNED;
  logic [31:0]                 RX_WORDS;
  logic [15:0]                 RX_ERRORS;

  // Model of the transmit side. The exp_ values are what the DUT shows after the next edge.
  link_pkg::link_state_t       m_state;
  cnt_t                        m_cnt;
  logic [link_pkg::DATA_W-1:0] m_test;
  logic [link_pkg::DATA_W-1:0] exp_dout;
  logic                        exp_push;
  logic                        exp_phy;
  logic                        exp_data;

  logic [7:0]                  ops[$];
  int                          arg_a[$];
  int                          arg_b[$];
  logic [31:0]                 rng;
  int                          corrupt_left;
  int                          value_errors;
  int                          other_errors;
  int                          cycles = 0;
  int                          cycle_limit = 1000;

  tb_clock u_clock (
    .CLK  (CLK),
    .RSTX (RSTX)
  );

  link_test_top uut (
    .CLK        (CLK),
    .RSTX       (RSTX),
    .CLR        (CLR),
    .DOPULL     (DOPULL),
    .DOPUSH     (DOPUSH),
    .PHY_INIT   (PHY_INIT),
    .DOUT       (DOUT),
    .RX_VALID   (RX_VALID),
    .RX_DATA    (RX_DATA),
    .RX_ALIGNED (RX_ALIGNED),
    .RX_WORDS   (RX_WORDS),
    .RX_ERRORS  (RX_ERRORS)
  );

  bind link_train_ctrl link_test_assertions u_assert (
    .CLK      (CLK),
    .RSTX     (RSTX),
    .CLR      (CLR),
    .DOPULL   (DOPULL),
    .PHY_INIT (PHY_INIT),
    .state    (state),
    .cnt      (cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int words_in_phase(input link_pkg::link_state_t s);
    case (s)
      link_pkg::INIT:         return link_pkg::INIT_LEN;
      link_pkg::DELAY_ADJUST: return link_pkg::ADJUST_LEN;
      link_pkg::WORD_ALIGN:   return link_pkg::ALIGN_LEN;
      default:                return link_pkg::DATA_LEN;
    endcase
  endfunction

  function automatic void reset_model();
    m_state  = link_pkg::INIT;
    m_cnt    = cnt_t'(link_pkg::INIT_LEN - 1);
    m_test   = '0;
    exp_dout = '0;
    exp_push = 1'b0;
    exp_phy  = 1'b0;
    exp_data = 1'b0;
  endfunction

  function automatic void model_step(input logic pull, input logic clr);
    if (clr) begin
      reset_model();
      return;
    end
    if (pull) begin
      if (m_cnt == '0) begin
        case (m_state)
          link_pkg::INIT:         m_state = link_pkg::DELAY_ADJUST;
          link_pkg::DELAY_ADJUST: m_state = link_pkg::WORD_ALIGN;
          link_pkg::WORD_ALIGN:   m_state = link_pkg::DATA_TRANSFER;
          default:                m_state = link_pkg::DELAY_ADJUST;
        endcase
        m_cnt = cnt_t'(words_in_phase(m_state) - 1);
      end else begin
        m_cnt = m_cnt - 1'b1;
      end
      if (m_state == link_pkg::DATA_TRANSFER) begin
        m_test = m_test + 64'd1;
      end
    end
    case (m_state)
      link_pkg::DELAY_ADJUST: begin
        exp_dout = (m_cnt > link_pkg::TOGGLE_LO && m_cnt < link_pkg::TOGGLE_HI) ?
                   link_pkg::TOGGLE_WORD : '0;
      end
      link_pkg::WORD_ALIGN:    exp_dout = link_pkg::ALIGN_WORD;
      link_pkg::DATA_TRANSFER: exp_dout = m_test;
      default:                 exp_dout = '0;
    endcase
    exp_push = pull && (m_state != link_pkg::INIT);
    exp_data = exp_push && (m_state == link_pkg::DATA_TRANSFER);
    exp_phy  = (m_state == link_pkg::DELAY_ADJUST) &&
               (m_cnt > link_pkg::PHY_INIT_LO) && (m_cnt < link_pkg::PHY_INIT_HI);
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      value_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // One cycle. Outputs of the last edge are checked and looped back, then the next inputs go out.
  task automatic step(input logic pull, input logic clr);
    logic [link_pkg::DATA_W-1:0] word;
    @(negedge CLK);
    check_value("DOUT", DOUT, exp_dout);
    check_value("DOPUSH", 64'(DOPUSH), 64'(exp_push));
    check_value("PHY_INIT", 64'(PHY_INIT), 64'(exp_phy));
    word = DOUT;
    if (DOPUSH && exp_data && corrupt_left > 0) begin
      if (corrupt_left == 1) begin
        word[7] = ~word[7];
      end
      corrupt_left--;
    end
    RX_VALID = DOPUSH;
    RX_DATA  = word;
    DOPULL   = pull;
    CLR      = clr;
    model_step(pull, clr);
  endtask

  task automatic run_cycles(input int count, input logic random_pull);
    int   n;
    logic pull;
    for (n = 0; n < count; n++) begin
      pull = 1'b1;
      if (random_pull) begin
        rng  = xorshift32(rng);
        pull = (rng[1:0] != 2'b00);  // Roughly one stall in four.
      end
      step(pull, 1'b0);
    end
  endtask

  task automatic clear_link();
    step(1'b0, 1'b1);
    step(1'b0, 1'b0);
    corrupt_left = 0;
    check_value("RX_ALIGNED", 64'(RX_ALIGNED), 64'd0);
    check_value("RX_WORDS", 64'(RX_WORDS), 64'd0);
    check_value("RX_ERRORS", 64'(RX_ERRORS), 64'd0);
  endtask

  task automatic check_counts(input int words, input int errors);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);  // The last looped word has reached the counters.
    check_value("RX_WORDS", 64'(RX_WORDS), 64'(words));
    check_value("RX_ERRORS", 64'(RX_ERRORS), 64'(errors));
  endtask

  task automatic load_trace();
    int               fd;
    int               n;
    int               a;
    int               b;
    logic [7:0]       op;
    logic [8*128-1:0] rest;
    fd = $fopen("testbench/link_trace.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("The trace file testbench/link_trace.txt could not be opened.");
      return;
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        break;
      end
      if (op == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%d %d", a, b);
        if (n != 2) begin
          other_errors++;
          $display("A trace line has fewer than two numbers after its command.");
        end
        ops.push_back(op);
        arg_a.push_back(a);
        arg_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  function automatic int trace_cycles();
    int total;
    total = 0;
    foreach (ops[i]) begin
      if (ops[i] == "R") begin
        total += arg_a[i];
      end else if (ops[i] == "C" || ops[i] == "K") begin
        total += 2;
      end
    end
    return total;
  endfunction

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout, the trace did not complete within %0d cycles.", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int idx;
    int asserts;
    DOPULL       = 1'b0;
    CLR          = 1'b0;
    RX_VALID     = 1'b0;
    RX_DATA      = '0;
    rng          = 32'd85;
    corrupt_left = 0;
    value_errors = 0;
    other_errors = 0;
    reset_model();
    load_trace();
    cycle_limit = trace_cycles() + MARGIN;
    wait (RSTX === 1'b1);
    for (idx = 0; idx < ops.size(); idx++) begin
      case (ops[idx])
        "R":     run_cycles(arg_a[idx], arg_b[idx] != 0);
        "C":     clear_link();
        "X":     corrupt_left = arg_a[idx];
        "K":     check_counts(arg_a[idx], arg_b[idx]);
        default: begin
          other_errors++;
          $display("The trace holds an unknown command.");
        end
      endcase
    end
    asserts = uut.u_ctrl.u_assert.fail_count;
    $display("Errors: %0d value mismatches, %0d assertion failures, %0d other failures",
             value_errors, asserts, other_errors);
    if (value_errors == 0 && asserts == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verilog/link_rx_checker.sv
`timescale 1ns/1ps

module link_rx_checker (
  input  logic                        CLK,
  input  logic                        RSTX,
  input  logic                        CLR,
  input  logic                        RX_VALID,
  input  logic [link_pkg::DATA_W-1:0] RX_DATA,
  output logic                        RX_ALIGNED,
  output logic [31:0]                 RX_WORDS,
  output logic [15:0]                 RX_ERRORS
);

  logic [link_pkg::DATA_W-1:0] expected;
  logic [link_pkg::DATA_W-1:0] base;
  logic [link_pkg::CNT_W-1:0]  idx;
  logic                        first_word;
  logic                        last_word;
  logic                        align_hit;
  logic                        data_word;
  logic                        mismatch;

  assign align_hit  = RX_VALID && !RX_ALIGNED && (RX_DATA == link_pkg::ALIGN_WORD);
  assign data_word  = RX_VALID && RX_ALIGNED;
  assign first_word = (idx == '0);
  assign last_word  = (idx == link_pkg::phase_last(link_pkg::DATA_TRANSFER));

  // The first data word after alignment sets the start value and cannot miss.
  assign mismatch = data_word && !first_word && (RX_DATA != expected);

  // A bad word still advances the expected value, so it is counted once.
  assign base = first_word ? RX_DATA : expected;

  always_ff @(posedge CLK) begin
    if (data_word) begin
      expected <= base + 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      RX_ALIGNED <= 1'b0;
      idx        <= '0;
    end else if (CLR) begin
      RX_ALIGNED <= 1'b0;
      idx        <= '0;
    end else if (align_hit) begin
      RX_ALIGNED <= 1'b1;
      idx        <= '0;
    end else if (data_word) begin
      if (last_word) begin
        RX_ALIGNED <= 1'b0;  // Frame done, look for the next alignment word.
        idx        <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      RX_WORDS  <= '0;
      RX_ERRORS <= '0;
    end else if (CLR) begin
      RX_WORDS  <= '0;
      RX_ERRORS <= '0;
    end else begin
      if (data_word) begin
        RX_WORDS <= RX_WORDS + 1'b1;
      end
      if (mismatch) begin
        RX_ERRORS <= RX_ERRORS + 1'b1;
      end
    end
  end

endmodule

// File: verilog/link_test_top.sv
`timescale 1ns/1ps

module link_test_top (
  input  logic                        CLK,
  input  logic                        RSTX,
  input  logic                        CLR,
  input  logic                        DOPULL,
  output logic                        DOPUSH,
  output logic                        PHY_INIT,
  output logic [link_pkg::DATA_W-1:0] DOUT,
  input  logic                        RX_VALID,
  input  logic [link_pkg::DATA_W-1:0] RX_DATA,
  output logic                        RX_ALIGNED,
  output logic [31:0]                 RX_WORDS,
  output logic [15:0]                 RX_ERRORS
);

  link_tx_if tx ();

  // Training sequencer, drives PHY_INIT and the next-cycle view.
  link_train_ctrl u_ctrl (
    .CLK      (CLK),
    .RSTX     (RSTX),
    .CLR      (CLR),
    .DOPULL   (DOPULL),
    .PHY_INIT (PHY_INIT),
    .tx       (tx.ctrl)
  );

  link_tx_datapath u_tx_dp (
    .CLK    (CLK),
    .RSTX   (RSTX),
    .tx     (tx.dp),
    .DOPUSH (DOPUSH),
    .DOUT   (DOUT)
  );

  // The receive side sees whatever is looped back outside this block.
  link_rx_checker u_rx_chk (
    .CLK        (CLK),
    .RSTX       (RSTX),
    .CLR        (CLR),
    .RX_VALID   (RX_VALID),
    .RX_DATA    (RX_DATA),
    .RX_ALIGNED (RX_ALIGNED),
    .RX_WORDS   (RX_WORDS),
    .RX_ERRORS  (RX_ERRORS)
  );

endmodule
